// File: hw/pmu_config.svh
/* PMU build configuration
   Data width, counter and event counts and the register word map */
`ifndef PMU_CONFIG_SVH
`define PMU_CONFIG_SVH

// --------------------
// Sizes
`define PMU_REG_WIDTH      32
`define PMU_N_COUNTERS     4
`define PMU_N_EVENTS       32
`define PMU_XBAR_SEL_BITS  5
`define PMU_ADDR_WIDTH     4

// --------------------
// Register word addresses
`define PMU_ADDR_CFG          4'd0
// Counters take CNT0 up to CNT0 + N_COUNTERS - 1
`define PMU_ADDR_CNT0         4'd1
`define PMU_ADDR_OVF_MASK     4'd5
`define PMU_ADDR_OVF_VECT     4'd6
`define PMU_ADDR_QUOTA_MASK   4'd7
`define PMU_ADDR_QUOTA_LIMIT  4'd8
`define PMU_ADDR_XBAR         4'd9

`endif

// File: hw/pmu_pkg.sv
/* PMU types shared by the bus slave and the counting blocks */
`include "pmu_config.svh"

package pmu_pkg;

    // Bus word and address
    typedef logic [`PMU_REG_WIDTH-1:0]  word_t;
    typedef logic [`PMU_ADDR_WIDTH-1:0] reg_addr_t;

    // One bit per counter, and a counter index
    typedef logic [`PMU_N_COUNTERS-1:0]         cnt_mask_t;
    typedef logic [$clog2(`PMU_N_COUNTERS)-1:0] cnt_idx_t;

    // Crossbar select field and the full counter bank
    typedef logic [`PMU_XBAR_SEL_BITS-1:0] xbar_sel_t;
    typedef word_t [`PMU_N_COUNTERS-1:0]   cnt_vals_t;

    // Main configuration word, bit 0 sits at the bottom
    typedef struct packed {
        logic [`PMU_REG_WIDTH-6:0] spare;
        logic                      quota_softrst;
        logic                      ovf_softrst;
        logic                      ovf_en;
        logic                      softrst;
        logic                      en;
    } pmu_cfg_fields_t;

    // Bus side writes raw, logic side reads fields
    typedef union packed {
        word_t           raw;
        pmu_cfg_fields_t fields;
    } pmu_cfg_u;

endpackage

// File: hw/pmu_cfg_if.sv
/* Internal PMU link between the register bank and the counting logic */
`include "pmu_config.svh"

interface pmu_cfg_if ();

    // Configuration from the register bank
    pmu_pkg::pmu_cfg_u                            cfg;
    pmu_pkg::cnt_mask_t                           ovf_mask;
    pmu_pkg::cnt_mask_t                           quota_mask;
    pmu_pkg::word_t                               quota_limit;
    pmu_pkg::xbar_sel_t [`PMU_N_COUNTERS-1:0]     xbar_sel;

    // One-cycle counter load request
    logic                                         cnt_we;
    pmu_pkg::cnt_idx_t                            cnt_idx;
    pmu_pkg::word_t                               cnt_wdata;

    // Status back toward the bus
    pmu_pkg::cnt_vals_t                           cnt_vals;
    pmu_pkg::cnt_mask_t                           ovf_vect;

    modport regs (
        output cfg, ovf_mask, quota_mask, quota_limit, xbar_sel,
        output cnt_we, cnt_idx, cnt_wdata,
        input  cnt_vals, ovf_vect
    );
    modport xbar (input xbar_sel);
    modport cnt (input cfg, ovf_mask, cnt_we, cnt_idx, cnt_wdata, output cnt_vals, ovf_vect);
    modport quota (input cfg, quota_mask, quota_limit, cnt_vals);

endinterface

// File: hw/pmu_wb_regs.sv
/* PMU Wishbone classic slave
   Owns the register bank, forwards counter loads and reads back status */
`include "pmu_config.svh"

module pmu_wb_regs (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  pmu_pkg::reg_addr_t wb_adr_i,
    input  pmu_pkg::word_t     wb_dat_i,
    output pmu_pkg::word_t     wb_dat_o,
    output logic               wb_ack_o,
    pmu_cfg_if.regs            cfg_bus
);

    logic               access;
    logic               wr_en;
    logic               cnt_hit;
    pmu_pkg::cnt_idx_t  cnt_idx;
    pmu_pkg::word_t     rdata;

    // Software visible registers
    pmu_pkg::pmu_cfg_u  cfg_q;
    pmu_pkg::cnt_mask_t ovf_mask_q;
    pmu_pkg::cnt_mask_t quota_mask_q;
    pmu_pkg::word_t     quota_limit_q;
    pmu_pkg::word_t     xbar_q;

    // --------------------
    // Access decode
    // Strobe seen with ack low starts the single wait cycle
    assign access  = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign wr_en   = access & wb_we_i;
    assign cnt_hit = (wb_adr_i >= `PMU_ADDR_CNT0) &&
                     (wb_adr_i < `PMU_ADDR_CNT0 + `PMU_N_COUNTERS);
    assign cnt_idx = pmu_pkg::cnt_idx_t'(wb_adr_i - `PMU_ADDR_CNT0);

    // Read mux, counters and overflow vector are live values
    always_comb begin
        rdata = '0;
        if (cnt_hit) begin
            rdata = cfg_bus.cnt_vals[cnt_idx];
        end else begin
            case (wb_adr_i)
                `PMU_ADDR_CFG:         rdata = cfg_q.raw;
                `PMU_ADDR_OVF_MASK:    rdata = pmu_pkg::word_t'(ovf_mask_q);
                `PMU_ADDR_OVF_VECT:    rdata = pmu_pkg::word_t'(cfg_bus.ovf_vect);
                `PMU_ADDR_QUOTA_MASK:  rdata = pmu_pkg::word_t'(quota_mask_q);
                `PMU_ADDR_QUOTA_LIMIT: rdata = quota_limit_q;
                `PMU_ADDR_XBAR:        rdata = xbar_q;
                // Unmapped words read zero
                default:               rdata = '0;
            endcase
        end
    end

    // --------------------
    // Ack, read data and register writes
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wb_ack_o      <= 1'b0;
            wb_dat_o      <= '0;
            cfg_q         <= '0;
            ovf_mask_q    <= '0;
            quota_mask_q  <= '0;
            quota_limit_q <= '0;
            xbar_q        <= '0;
        end else begin
            wb_ack_o <= access;
            // Read word is held for the ack cycle
            if (access && !wb_we_i) begin
                wb_dat_o <= rdata;
            end
            // Register updates on the edge that raises ack
            if (wr_en) begin
                case (wb_adr_i)
                    `PMU_ADDR_CFG:         cfg_q.raw     <= wb_dat_i;
                    `PMU_ADDR_OVF_MASK:    ovf_mask_q    <= wb_dat_i[`PMU_N_COUNTERS-1:0];
                    `PMU_ADDR_QUOTA_MASK:  quota_mask_q  <= wb_dat_i[`PMU_N_COUNTERS-1:0];
                    `PMU_ADDR_QUOTA_LIMIT: quota_limit_q <= wb_dat_i;
                    `PMU_ADDR_XBAR:        xbar_q        <= wb_dat_i;
                    // Overflow vector, counters and holes take no write here
                    default: ;
                endcase
            end
        end
    end

    // --------------------
    // Toward the counting logic
    assign cfg_bus.cfg         = cfg_q;
    assign cfg_bus.ovf_mask    = ovf_mask_q;
    assign cfg_bus.quota_mask  = quota_mask_q;
    assign cfg_bus.quota_limit = quota_limit_q;

    // Counter write becomes a load on the ack edge
    assign cfg_bus.cnt_we    = wr_en & cnt_hit;
    assign cfg_bus.cnt_idx   = cnt_idx;
    assign cfg_bus.cnt_wdata = wb_dat_i;

    // Select field j sits at bits 5j up to 5j+4
    for (genvar j = 0; j < `PMU_N_COUNTERS; j++) begin : g_xbar_sel
        assign cfg_bus.xbar_sel[j] =
            xbar_q[j*`PMU_XBAR_SEL_BITS +: `PMU_XBAR_SEL_BITS];
    end

endmodule

// File: hw/pmu_crossbar.sv
/* PMU event crossbar
   Routes one SoC event to each counter through a register stage */
`include "pmu_config.svh"

module pmu_crossbar (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic [`PMU_N_EVENTS-1:0] events_i,
    pmu_cfg_if.xbar                  cfg_bus,
    output pmu_pkg::cnt_mask_t       routed_o
);

    pmu_pkg::cnt_mask_t sel_d;

    // One wide mux per counter
    always_comb begin
        for (int j = 0; j < `PMU_N_COUNTERS; j++) begin
            sel_d[j] = events_i[cfg_bus.xbar_sel[j]];
        end
    end

    // Register stage, adds one cycle of latency
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            routed_o <= '0;
        end else begin
            routed_o <= sel_d;
        end
    end

endmodule

// File: hw/pmu_counters.sv
/* PMU event counters
   Count routed events, take bus loads and flag wraps into the overflow vector */
`include "pmu_config.svh"

module pmu_counters (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  pmu_pkg::cnt_mask_t routed_i,
    pmu_cfg_if.cnt             cfg_bus,
    output logic               intr_overflow_o
);

    pmu_pkg::cnt_vals_t cnt_q;
    pmu_pkg::cnt_mask_t ovf_q;
    pmu_pkg::cnt_mask_t load_hit;
    pmu_pkg::cnt_mask_t inc_hit;
    pmu_pkg::cnt_mask_t wrap;

    // --------------------
    // Per-counter action this cycle
    always_comb begin
        for (int i = 0; i < `PMU_N_COUNTERS; i++) begin
            load_hit[i] = cfg_bus.cnt_we && (cfg_bus.cnt_idx == pmu_pkg::cnt_idx_t'(i));
            // Bus load and soft reset both beat the increment
            inc_hit[i]  = cfg_bus.cfg.fields.en & routed_i[i] & ~load_hit[i] &
                          ~cfg_bus.cfg.fields.softrst;
            // Wrap from all ones back to zero
            wrap[i]     = inc_hit[i] && (cnt_q[i] == '1);
        end
    end

    // Counter bank
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            cnt_q <= '0;
        end else if (cfg_bus.cfg.fields.softrst) begin
            // Held clear for as long as softrst stays set
            cnt_q <= '0;
        end else begin
            for (int i = 0; i < `PMU_N_COUNTERS; i++) begin
                if (load_hit[i]) begin
                    cnt_q[i] <= cfg_bus.cnt_wdata;
                end else if (inc_hit[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    // --------------------
    // Sticky overflow flags and masked interrupt
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ovf_q           <= '0;
            intr_overflow_o <= 1'b0;
        end else begin
            if (cfg_bus.cfg.fields.ovf_softrst) begin
                ovf_q <= '0;
            end else if (cfg_bus.cfg.fields.ovf_en) begin
                ovf_q <= ovf_q | wrap;
            end
            // Follows the flags one cycle later
            intr_overflow_o <= |(ovf_q & cfg_bus.ovf_mask);
        end
    end

    // Status for the bus and the quota checker
    assign cfg_bus.cnt_vals = cnt_q;
    assign cfg_bus.ovf_vect = ovf_q;

endmodule

// File: hw/pmu_quota.sv
/* PMU quota checker
   Sums the masked counters and holds an interrupt once the limit is passed */
`include "pmu_config.svh"

module pmu_quota (
    input  logic     clk_i,
    input  logic     rstn_i,
    pmu_cfg_if.quota cfg_bus,
    output logic     intr_quota_o
);

    pmu_pkg::word_t sum_d;
    pmu_pkg::word_t sum_q;

    // Masked sum, carries out of bit 31 are dropped
    always_comb begin
        sum_d = '0;
        for (int i = 0; i < `PMU_N_COUNTERS; i++) begin
            if (cfg_bus.quota_mask[i]) begin
                sum_d = sum_d + cfg_bus.cnt_vals[i];
            end
        end
    end

    // --------------------
    // Sum register, then the sticky compare
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            sum_q        <= '0;
            intr_quota_o <= 1'b0;
        end else begin
            sum_q <= sum_d;
            if (cfg_bus.cfg.fields.quota_softrst) begin
                intr_quota_o <= 1'b0;
            end else if (sum_q > cfg_bus.quota_limit) begin
                // Stays high until the quota soft reset
                intr_quota_o <= 1'b1;
            end
        end
    end

endmodule

// File: hw/pmu_top.sv
/* PMU top level
   Wishbone slave, event crossbar, counters and quota checker */
`include "pmu_config.svh"

module pmu_top (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    // Wishbone classic slave
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  pmu_pkg::reg_addr_t       wb_adr_i,
    input  pmu_pkg::word_t           wb_dat_i,
    output pmu_pkg::word_t           wb_dat_o,
    output logic                     wb_ack_o,
    // SoC events and interrupts
    input  logic [`PMU_N_EVENTS-1:0] events_i,
    output logic                     intr_overflow_o,
    output logic                     intr_quota_o
);

    // Registered crossbar outputs, one per counter
    pmu_pkg::cnt_mask_t routed;

    pmu_cfg_if cfg_bus ();

    // --------------------
    // Register bank on the bus
    pmu_wb_regs u_regs (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .cfg_bus  (cfg_bus)
    );

    // Event routing
    pmu_crossbar u_xbar (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .events_i (events_i),
        .cfg_bus  (cfg_bus),
        .routed_o (routed)
    );

    // --------------------
    // Counting and interrupts
    pmu_counters u_counters (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .routed_i        (routed),
        .cfg_bus         (cfg_bus),
        .intr_overflow_o (intr_overflow_o)
    );

    pmu_quota u_quota (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .cfg_bus      (cfg_bus),
        .intr_quota_o (intr_quota_o)
    );

endmodule

// File: verification/pmu_tb.sv
/* PMU testbench
   Wishbone driver, register and counter model, five directed and random tests */
`include "pmu_config.svh"

module pmu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ack_timeout  = 20;
    localparam int poll_timeout = 20;

    logic        clk_i;
    logic        rstn_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [3:0]  wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic [31:0] events_i;
    logic        intr_overflow_o;
    logic        intr_quota_o;

    // Register and counter model
    logic [31:0] m_cfg;
    logic [31:0] m_cnt [4];
    logic [3:0]  m_ovf_mask;
    logic [3:0]  m_ovf_vect;
    logic [3:0]  m_qmask;
    logic [31:0] m_qlimit;
    logic [31:0] m_xbar;
    logic        m_intr_quota;

    // Reads waiting for the compare process
    logic [3:0]  adr_q [$];
    logic [31:0] got_q [$];
    logic [31:0] exp_q [$];
    logic [3:0]  c_adr;
    logic [31:0] c_got;
    logic [31:0] c_exp;

    integer seed;
    int     errors;
    int     reads;
    int     test_no;
    int     test_err_base;

    pmu_top u_dut (.*);

    always #2 clk_i = ~clk_i;

    // --------------------
    // Reference model
    function automatic logic [31:0] ref_read(input logic [3:0] adr);
        case (adr)
            `PMU_ADDR_CFG:                return m_cfg;
            4'd1, 4'd2, 4'd3, 4'd4:       return m_cnt[2'(adr - `PMU_ADDR_CNT0)];
            `PMU_ADDR_OVF_MASK:           return {28'b0, m_ovf_mask};
            `PMU_ADDR_OVF_VECT:           return {28'b0, m_ovf_vect};
            `PMU_ADDR_QUOTA_MASK:         return {28'b0, m_qmask};
            `PMU_ADDR_QUOTA_LIMIT:        return m_qlimit;
            `PMU_ADDR_XBAR:               return m_xbar;
            default:                      return 32'h0;
        endcase
    endfunction

    // Sticky quota flag from the masked sum, which wraps at 32 bits
    function automatic void quota_eval();
        logic [31:0] sum;
        sum = '0;
        for (int i = 0; i < 4; i++) begin
            if (m_qmask[i]) begin
                sum = sum + m_cnt[i];
            end
        end
        if (!m_cfg[4] && sum > m_qlimit) begin
            m_intr_quota = 1'b1;
        end
    endfunction

    function automatic void model_write(input logic [3:0] adr, input logic [31:0] data);
        case (adr)
            `PMU_ADDR_CFG: begin
                m_cfg = data;
                // softrst, ovf_softrst and quota_softrst
                if (data[1]) begin
                    for (int i = 0; i < 4; i++) begin
                        m_cnt[i] = '0;
                    end
                end
                if (data[3]) begin
                    m_ovf_vect = '0;
                end
                if (data[4]) begin
                    m_intr_quota = 1'b0;
                end
            end
            4'd1, 4'd2, 4'd3, 4'd4: begin
                if (!m_cfg[1]) begin
                    m_cnt[2'(adr - `PMU_ADDR_CNT0)] = data;
                end
            end
            `PMU_ADDR_OVF_MASK:    m_ovf_mask = data[3:0];
            `PMU_ADDR_QUOTA_MASK:  m_qmask = data[3:0];
            `PMU_ADDR_QUOTA_LIMIT: m_qlimit = data;
            `PMU_ADDR_XBAR:        m_xbar = data;
            default: ;
        endcase
        quota_eval();
    endfunction

    // Counts one cycle of driven events the way the counters will
    function automatic void model_count(input logic [31:0] ev);
        logic [4:0] sel;
        for (int i = 0; i < 4; i++) begin
            sel = m_xbar[5*i +: 5];
            if (m_cfg[0] && !m_cfg[1] && ev[sel]) begin
                if (m_cnt[i] == 32'hFFFF_FFFF && m_cfg[2] && !m_cfg[3]) begin
                    m_ovf_vect[i] = 1'b1;
                end
                m_cnt[i] = m_cnt[i] + 32'd1;
            end
        end
        quota_eval();
    endfunction

    function automatic void report_mismatch(input string name, input logic [31:0] got,
                                            input logic [31:0] exp);
        $display("Error at %0d ns: %s = %08h, expected %08h", $time, name, got, exp);
        errors++;
    endfunction

    // --------------------
    // Bus driver
    task automatic idle(input int n);
        repeat (n) @(posedge clk_i);
        #1;
    endtask

    task automatic wait_ack(input logic [3:0] adr);
        int n;
        n = 0;
        @(posedge clk_i);
        #1;
        while (wb_ack_o !== 1'b1) begin
            if (n >= ack_timeout) begin
                $display("No ack from the DUT for address %0d within %0d cycles", adr, n);
                $display("test failed");
                $finish;
            end
            n++;
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic bus_write(input logic [3:0] adr, input logic [31:0] data);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b1;
        wb_adr_i = adr;
        wb_dat_i = data;
        wait_ack(adr);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        model_write(adr, data);
    endtask

    task automatic bus_read(input logic [3:0] adr);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b0;
        wb_adr_i = adr;
        wait_ack(adr);
        // Data is valid while ack is high
        adr_q.push_back(adr);
        got_q.push_back(wb_dat_o);
        exp_q.push_back(ref_read(adr));
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
    endtask

    task automatic count_events(input int cycles, input logic use_rand, input logic [31:0] ev);
        logic [31:0] cur;
        for (int c = 0; c < cycles; c++) begin
            cur = use_rand ? $random(seed) : ev;
            events_i = cur;
            model_count(cur);
            idle(1);
        end
        events_i = '0;
    endtask

    task automatic finish_test(input string name);
        idle(1);
        $display("Test %0d %s: %0d errors", test_no, name, errors - test_err_base);
        test_no++;
        test_err_base = errors;
    endtask

    // Drains the queued reads on the next edge
    always @(posedge clk_i) begin
        while (got_q.size() > 0) begin
            c_adr = adr_q.pop_front();
            c_got = got_q.pop_front();
            c_exp = exp_q.pop_front();
            reads++;
            if (c_got !== c_exp) begin
                report_mismatch($sformatf("wb_dat_o (address %0d)", c_adr), c_got, c_exp);
            end
        end
    end

    // --------------------
    // Tests
    task automatic reset_and_readback();
        // Ack and both interrupts start low
        if (wb_ack_o !== 1'b0) begin
            report_mismatch("wb_ack_o", 32'(wb_ack_o), 32'h0);
        end
        if (intr_overflow_o !== 1'b0) begin
            report_mismatch("intr_overflow_o", 32'(intr_overflow_o), 32'h0);
        end
        if (intr_quota_o !== 1'b0) begin
            report_mismatch("intr_quota_o", 32'(intr_quota_o), 32'h0);
        end
        for (int a = 0; a < 16; a++) begin
            bus_read(4'(a));
        end
        // Low five bits clear so no control field moves
        bus_write(`PMU_ADDR_CFG, 32'hA5A5_A5A0);
        bus_write(`PMU_ADDR_OVF_MASK, 32'h0000_000A);
        bus_write(`PMU_ADDR_QUOTA_MASK, 32'h0000_0005);
        bus_write(`PMU_ADDR_QUOTA_LIMIT, 32'h1234_5678);
        bus_write(`PMU_ADDR_XBAR, 32'h0A41_8820);
        bus_write(`PMU_ADDR_OVF_VECT, 32'h0000_000F);
        for (int a = 10; a < 16; a++) begin
            bus_write(4'(a), 32'hFFFF_FFFF);
        end
        for (int a = 0; a < 16; a++) begin
            bus_read(4'(a));
        end
        bus_write(`PMU_ADDR_CFG, 32'h0);
        finish_test("reset and readback");
    endtask

    task automatic routed_counting();
        logic [4:0]  sel [4];
        logic [31:0] sel_word;
        logic [31:0] rnd;
        logic        dup;
        sel_word = '0;
        // Four distinct random event selects
        for (int j = 0; j < 4; j++) begin
            dup = 1'b1;
            while (dup) begin
                rnd = $random(seed);
                sel[j] = rnd[4:0];
                dup = 1'b0;
                for (int k = 0; k < j; k++) begin
                    if (sel[k] == sel[j]) begin
                        dup = 1'b1;
                    end
                end
            end
            sel_word[5*j +: 5] = sel[j];
        end
        bus_write(`PMU_ADDR_CFG, 32'h2);
        bus_write(`PMU_ADDR_CFG, 32'h0);
        bus_write(`PMU_ADDR_XBAR, sel_word);
        bus_write(`PMU_ADDR_CFG, 32'h1);
        count_events(40, 1'b1, '0);
        idle(3);
        bus_write(`PMU_ADDR_CFG, 32'h0);
        for (int a = 1; a <= 4; a++) begin
            bus_read(4'(a));
        end
        finish_test("routed counting");
    endtask

    task automatic load_and_softrst();
        for (int a = 1; a <= 4; a++) begin
            bus_write(4'(a), $random(seed));
        end
        for (int a = 1; a <= 4; a++) begin
            bus_read(4'(a));
        end
        bus_write(`PMU_ADDR_CFG, 32'h2);
        bus_write(`PMU_ADDR_CFG, 32'h0);
        for (int a = 1; a <= 4; a++) begin
            bus_read(4'(a));
        end
        finish_test("bus load and soft reset");
    endtask

    task automatic overflow_flags();
        int n;
        bus_write(`PMU_ADDR_CNT0, 32'hFFFF_FFFE);
        // Counter 0 takes event 7 and the others take idle events 0 to 2
        bus_write(`PMU_ADDR_XBAR, 32'h0001_0407);
        bus_write(`PMU_ADDR_OVF_MASK, 32'h0);
        bus_write(`PMU_ADDR_CFG, 32'h5);
        count_events(2, 1'b0, 32'h0000_0080);
        idle(3);
        bus_read(`PMU_ADDR_CNT0);
        bus_read(`PMU_ADDR_OVF_VECT);
        // Masked off so the interrupt stays low
        if (intr_overflow_o !== 1'b0) begin
            report_mismatch("intr_overflow_o", 32'(intr_overflow_o), 32'h0);
        end
        bus_write(`PMU_ADDR_OVF_MASK, 32'h1);
        n = 0;
        while (intr_overflow_o !== 1'b1 && n < poll_timeout) begin
            idle(1);
            n++;
        end
        if (intr_overflow_o !== 1'b1) begin
            $display("intr_overflow_o did not rise within %0d cycles of its mask bit", n);
            errors++;
        end
        bus_write(`PMU_ADDR_CFG, 32'hD);
        bus_write(`PMU_ADDR_CFG, 32'h0);
        bus_read(`PMU_ADDR_OVF_VECT);
        idle(2);
        // ovf_softrst leaves the interrupt low as well
        if (intr_overflow_o !== 1'b0) begin
            report_mismatch("intr_overflow_o", 32'(intr_overflow_o), 32'h0);
        end
        finish_test("overflow");
    endtask

    task automatic quota_interrupt();
        // Clear counters and any earlier quota interrupt
        bus_write(`PMU_ADDR_CFG, 32'h12);
        bus_write(`PMU_ADDR_CFG, 32'h0);
        bus_write(`PMU_ADDR_QUOTA_MASK, 32'h5);
        bus_write(`PMU_ADDR_QUOTA_LIMIT, 32'd40);
        bus_write(`PMU_ADDR_CFG, 32'h1);
        for (int c = 0; c < 8; c++) begin
            count_events(10, 1'b1, '0);
            idle(4);
            if (intr_quota_o !== m_intr_quota) begin
                report_mismatch("intr_quota_o", 32'(intr_quota_o), 32'(m_intr_quota));
            end
        end
        if (!m_intr_quota) begin
            $display("Quota limit was never crossed, sticky behavior not covered");
            errors++;
        end
        // The interrupt holds while the counters return to zero
        bus_write(`PMU_ADDR_CFG, 32'h2);
        bus_write(`PMU_ADDR_CFG, 32'h0);
        idle(4);
        if (intr_quota_o !== m_intr_quota) begin
            report_mismatch("intr_quota_o", 32'(intr_quota_o), 32'(m_intr_quota));
        end
        bus_write(`PMU_ADDR_CFG, 32'h10);
        idle(2);
        if (intr_quota_o !== m_intr_quota) begin
            report_mismatch("intr_quota_o", 32'(intr_quota_o), 32'(m_intr_quota));
        end
        finish_test("quota");
    endtask

    // --------------------
    // Main sequence
    initial begin
        clk_i = 1'b0;
        rstn_i = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        events_i = '0;
        seed = 32'h22a7;
        errors = 0;
        reads = 0;
        test_no = 1;
        test_err_base = 0;
        m_cfg = '0;
        for (int i = 0; i < 4; i++) begin
            m_cnt[i] = '0;
        end
        m_ovf_mask = '0;
        m_ovf_vect = '0;
        m_qmask = '0;
        m_qlimit = '0;
        m_xbar = '0;
        m_intr_quota = 1'b0;
        idle(2);
        rstn_i = 1'b1;
        reset_and_readback();
        routed_counting();
        load_and_softrst();
        overflow_flags();
        quota_interrupt();
        $display("Summary: %0d tests, %0d reads checked, %0d errors", test_no - 1, reads, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+hw
hw/pmu_pkg.sv
hw/pmu_cfg_if.sv
hw/pmu_wb_regs.sv
hw/pmu_crossbar.sv
hw/pmu_counters.sv
hw/pmu_quota.sv
hw/pmu_top.sv
verification/pmu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir

verilator --binary --timing --top-module pmu_tb -f sim.f -o pmu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/pmu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Pass only if the testbench printed its pass line
if grep -qx "test passed" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
